// ==== led_panel_pkg.sv ====
`default_nettype none

package led_panel_pkg;

    // panel geometry, one half is 32 rows of 64 columns
    localparam int COL_BITS  = 6;
    localparam int ADDR_BITS = 5;
    localparam int COL_COUNT = 64;
    localparam int ROW_COUNT = 32;
    localparam int PIX_COUNT = COL_COUNT * ROW_COUNT; // words per half

    localparam int SUBFRAME_BITS = 8;
    localparam int CHAN_BITS     = 8;

    // scan timing in clk cycles
    localparam int BEAT_PERIOD = 2;
    localparam int ROW_GAP     = 4;  // room for blank, latch and unblank
    localparam int ROW_CYCLES  = COL_COUNT * BEAT_PERIOD + ROW_GAP;
    localparam int PHASE_BITS  = $clog2(BEAT_PERIOD + ROW_GAP);

    typedef logic [COL_BITS-1:0]           col_t;
    typedef logic [ADDR_BITS-1:0]          row_addr_t;
    typedef logic [SUBFRAME_BITS-1:0]      subframe_t;
    typedef logic [CHAN_BITS-1:0]          chan_t;
    typedef logic [PHASE_BITS-1:0]         phase_t;
    typedef logic [ADDR_BITS+COL_BITS-1:0] pix_index_t; // {row address, column}

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    typedef struct packed {
        rgb565_t upper; // rows 0 to 31
        rgb565_t lower; // rows 32 to 63
    } rgb565_pair_t;

    // one bit per colour as the panel takes it, red in bit 0
    typedef struct packed {
        logic blue;
        logic green;
        logic red;
    } rgb3_t;

    typedef struct packed {
        rgb3_t upper;
        rgb3_t lower;
    } rgb3_pair_t;

endpackage

`default_nettype wire

// ==== pixel_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// one column beat between pipeline stages
// valid is a single-cycle strobe, no back-pressure
interface pixel_if #(
    parameter type payload_t = logic  // position-only beats keep the default
);
    logic                       valid;
    led_panel_pkg::col_t        col;
    led_panel_pkg::row_addr_t   addr;
    led_panel_pkg::subframe_t   subframe;
    payload_t                   payload;

    modport src (
        output valid, col, addr, subframe, payload
    );

    modport dst (
        input valid, col, addr, subframe, payload
    );

endinterface

`default_nettype wire

// ==== scan_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module scan_counter (
    input  logic clk,
    input  logic pll_locked,
    pixel_if.src beat
);

    led_panel_pkg::phase_t phase;    // cycles left until next beat
    logic                  last_col;
    logic                  last_addr;

    // the beat fields are the scan position itself
    assign last_col  = (beat.col == led_panel_pkg::col_t'(led_panel_pkg::COL_COUNT - 1));
    assign last_addr = (beat.addr == led_panel_pkg::row_addr_t'(led_panel_pkg::ROW_COUNT - 1));

    assign beat.payload = '0;  // nothing but position here

    always_ff @(posedge clk or negedge pll_locked) begin
        if (!pll_locked) begin
            beat.valid    <= 1'b0;
            beat.col      <= '0;
            beat.addr     <= '0;
            beat.subframe <= '0;
            phase         <= led_panel_pkg::phase_t'(1);  // first beat one cycle later
        end else begin
            beat.valid <= (phase == '0);

            if (phase == '0) begin
                // row end gets the extra gap for the driver's latch sequence
                if (last_col) begin
                    phase <= led_panel_pkg::phase_t'(led_panel_pkg::BEAT_PERIOD - 1
                                                     + led_panel_pkg::ROW_GAP);
                end else begin
                    phase <= led_panel_pkg::phase_t'(led_panel_pkg::BEAT_PERIOD - 1);
                end
            end else begin
                phase <= phase - 1'b1;
            end

            // step the position once its beat has gone out
            if (beat.valid) begin
                beat.col <= beat.col + 1'b1;  // wraps at 64
                if (last_col) begin
                    beat.addr <= beat.addr + 1'b1;
                    if (last_addr) begin
                        beat.subframe <= beat.subframe + 1'b1;  // wraps at 256
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== frame_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module frame_buffer (
    input  logic                     clk,
    input  logic                     pll_locked,
    input  logic                     fb_wr,
    input  logic                     fb_wr_lower,
    input  led_panel_pkg::row_addr_t fb_wr_addr,
    input  led_panel_pkg::col_t      fb_wr_col,
    input  led_panel_pkg::rgb565_t   fb_wr_data,
    pixel_if.dst                     beat_in,
    pixel_if.src                     beat_out
);

    led_panel_pkg::rgb565_t     mem_upper [led_panel_pkg::PIX_COUNT];
    led_panel_pkg::rgb565_t     mem_lower [led_panel_pkg::PIX_COUNT];
    led_panel_pkg::pix_index_t  wr_index;
    led_panel_pkg::pix_index_t  rd_index;

    assign wr_index = {fb_wr_addr, fb_wr_col};
    assign rd_index = {beat_in.addr, beat_in.col};

    // write port, old data on a same-cycle read
    always_ff @(posedge clk) begin
        if (fb_wr && !fb_wr_lower) begin
            mem_upper[wr_index] <= fb_wr_data;
        end
        if (fb_wr && fb_wr_lower) begin
            mem_lower[wr_index] <= fb_wr_data;
        end
    end

    // read both halves for the scanned column
    always_ff @(posedge clk) begin
        if (beat_in.valid) begin
            beat_out.payload.upper <= mem_upper[rd_index];
            beat_out.payload.lower <= mem_lower[rd_index];
            beat_out.col           <= beat_in.col;
            beat_out.addr          <= beat_in.addr;
            beat_out.subframe      <= beat_in.subframe;
        end
    end

    always_ff @(posedge clk or negedge pll_locked) begin
        if (!pll_locked) begin
            beat_out.valid <= 1'b0;
        end else begin
            beat_out.valid <= beat_in.valid;
        end
    end

endmodule

`default_nettype wire

// ==== pwm_modulator.sv ====
`timescale 1ns/100ps
`default_nettype none

module pwm_modulator (
    input  logic clk,
    input  logic pll_locked,
    pixel_if.dst beat_in,
    pixel_if.src beat_out
);

    led_panel_pkg::subframe_t cmp;  // bit-reversed subframe

    // widen each channel by zero fill, lit when strictly above the threshold
    function automatic led_panel_pkg::rgb3_t modulate(
        input led_panel_pkg::rgb565_t   px,
        input led_panel_pkg::subframe_t thr
    );
        led_panel_pkg::chan_t red8;
        led_panel_pkg::chan_t green8;
        led_panel_pkg::chan_t blue8;
        led_panel_pkg::rgb3_t bits;
        red8       = {px.red, 3'b000};
        green8     = {px.green, 2'b00};
        blue8      = {px.blue, 3'b000};
        bits.red   = (red8 > thr);
        bits.green = (green8 > thr);
        bits.blue  = (blue8 > thr);
        return bits;
    endfunction

    // reversed order spreads the on time over the frame, less flicker
    always_comb begin
        for (int i = 0; i < led_panel_pkg::SUBFRAME_BITS; i++) begin
            cmp[i] = beat_in.subframe[led_panel_pkg::SUBFRAME_BITS - 1 - i];
        end
    end

    always_ff @(posedge clk) begin
        if (beat_in.valid) begin
            beat_out.payload.upper <= modulate(beat_in.payload.upper, cmp);
            beat_out.payload.lower <= modulate(beat_in.payload.lower, cmp);
            beat_out.col           <= beat_in.col;
            beat_out.addr          <= beat_in.addr;
            beat_out.subframe      <= beat_in.subframe;
        end
    end

    always_ff @(posedge clk or negedge pll_locked) begin
        if (!pll_locked) begin
            beat_out.valid <= 1'b0;
        end else begin
            beat_out.valid <= beat_in.valid;
        end
    end

endmodule

`default_nettype wire

// ==== panel_driver.sv ====
`timescale 1ns/100ps
`default_nettype none

module panel_driver (
    input  logic                     clk,
    input  logic                     pll_locked,
    pixel_if.dst                     beat_in,
    output led_panel_pkg::rgb3_t     rgb0,
    output led_panel_pkg::rgb3_t     rgb1,
    output led_panel_pkg::row_addr_t row_addr,
    output logic                     blank,
    output logic                     latch,
    output logic                     sclk
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_SHIFT_HIGH,  // colour on the pins, raise sclk next
        S_BLANK,       // last column clocked in, panel dark
        S_LATCH,       // latch pulse
        S_UNBLANK      // new row address showing
    } state_t;

    state_t                   state;
    logic                     take_beat;
    logic                     row_end;   // beat being shifted is column 63
    led_panel_pkg::row_addr_t row_next;  // address shown once the row is latched

    assign take_beat = beat_in.valid && (state == S_IDLE || state == S_UNBLANK);

    always_ff @(posedge clk) begin
        if (take_beat) begin
            row_next <= beat_in.addr;
        end
    end

    always_ff @(posedge clk or negedge pll_locked) begin
        if (!pll_locked) begin
            state    <= S_IDLE;
            rgb0     <= '0;
            rgb1     <= '0;
            row_addr <= '0;
            blank    <= 1'b1;  // dark until the first row is latched
            latch    <= 1'b0;
            sclk     <= 1'b0;
            row_end  <= 1'b0;
        end else begin
            sclk <= 1'b0;
            case (state)
                S_IDLE, S_UNBLANK: begin
                    state <= S_IDLE;
                    if (take_beat) begin
                        rgb0    <= beat_in.payload.upper;
                        rgb1    <= beat_in.payload.lower;
                        row_end <= (beat_in.col
                                    == led_panel_pkg::col_t'(led_panel_pkg::COL_COUNT - 1));
                        state   <= S_SHIFT_HIGH;
                    end
                end
                S_SHIFT_HIGH: begin
                    sclk <= 1'b1;
                    if (row_end) begin
                        blank <= 1'b1;  // goes dark with the last shift clock
                        state <= S_BLANK;
                    end else begin
                        state <= S_IDLE;
                    end
                end
                S_BLANK: begin
                    latch <= 1'b1;
                    state <= S_LATCH;
                end
                S_LATCH: begin
                    latch    <= 1'b0;
                    blank    <= 1'b0;
                    row_addr <= row_next;
                    state    <= S_UNBLANK;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== led_panel_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module led_panel_top (
    input  logic                     clk,
    input  logic                     pll_locked,
    input  logic                     fb_wr,
    input  logic                     fb_wr_lower,
    input  led_panel_pkg::row_addr_t fb_wr_addr,
    input  led_panel_pkg::col_t      fb_wr_col,
    input  led_panel_pkg::rgb565_t   fb_wr_data,
    output led_panel_pkg::rgb3_t     rgb0,
    output led_panel_pkg::rgb3_t     rgb1,
    output led_panel_pkg::row_addr_t row_addr,
    output logic                     blank,
    output logic                     latch,
    output logic                     sclk
);

    pixel_if beat_pos ();
    pixel_if #(.payload_t(led_panel_pkg::rgb565_pair_t)) beat_565 ();
    pixel_if #(.payload_t(led_panel_pkg::rgb3_pair_t))   beat_rgb3 ();

    scan_counter u_scan (
        .clk        (clk),
        .pll_locked (pll_locked),
        .beat       (beat_pos)
    );

    frame_buffer u_fb (
        .clk         (clk),
        .pll_locked  (pll_locked),
        .fb_wr       (fb_wr),
        .fb_wr_lower (fb_wr_lower),
        .fb_wr_addr  (fb_wr_addr),
        .fb_wr_col   (fb_wr_col),
        .fb_wr_data  (fb_wr_data),
        .beat_in     (beat_pos),
        .beat_out    (beat_565)
    );

    pwm_modulator u_pwm (
        .clk        (clk),
        .pll_locked (pll_locked),
        .beat_in    (beat_565),
        .beat_out   (beat_rgb3)
    );

    panel_driver u_drv (
        .clk        (clk),
        .pll_locked (pll_locked),
        .beat_in    (beat_rgb3),
        .rgb0       (rgb0),
        .rgb1       (rgb1),
        .row_addr   (row_addr),
        .blank      (blank),
        .latch      (latch),
        .sclk       (sclk)
    );

endmodule

`default_nettype wire

// ==== led_panel_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module led_panel_sva (
    input logic clk,
    input logic pll_locked,
    input logic blank,
    input logic latch,
    input logic sclk
);

    latch_one_cycle: assert property (
        @(posedge clk) disable iff (!pll_locked) latch |=> !latch
    ) else $error("latch held longer than one cycle");

    sclk_latch_apart: assert property (
        @(posedge clk) disable iff (!pll_locked) !(sclk && latch)
    ) else $error("sclk and latch high together");

    // panel must be dark while the new row loads
    blank_during_latch: assert property (
        @(posedge clk) disable iff (!pll_locked) latch |-> blank
    ) else $error("latch high with blank low");

    sclk_single_pulse: assert property (
        @(posedge clk) disable iff (!pll_locked) sclk |=> !sclk
    ) else $error("sclk high in two consecutive cycles");

endmodule

bind panel_driver led_panel_sva u_sva (
    .clk        (clk),
    .pll_locked (pll_locked),
    .blank      (blank),
    .latch      (latch),
    .sclk       (sclk)
);

`default_nettype wire

// ==== tb_led_panel.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_led_panel;

    localparam int CLK_PERIOD  = 40;
    localparam int PIX         = led_panel_pkg::COL_COUNT * led_panel_pkg::ROW_COUNT;
    localparam int PATTERN_ROW = 16;  // far enough down for the clear to stay ahead of the scan

    logic                     clk;
    logic                     pll_locked;
    logic                     fb_wr;
    logic                     fb_wr_lower;
    led_panel_pkg::row_addr_t fb_wr_addr;
    led_panel_pkg::col_t      fb_wr_col;
    led_panel_pkg::rgb565_t   fb_wr_data;
    led_panel_pkg::rgb3_t     rgb0;
    led_panel_pkg::rgb3_t     rgb1;
    led_panel_pkg::row_addr_t row_addr;
    logic                     blank;
    logic                     latch;
    logic                     sclk;

    led_panel_pkg::rgb565_t ref_upper [PIX];  // expected framebuffer contents
    led_panel_pkg::rgb565_t ref_lower [PIX];
    led_panel_pkg::rgb3_t   seen0 [PIX];      // last colour shifted out per pixel
    led_panel_pkg::rgb3_t   seen1 [PIX];
    int                     seen_sf [PIX];
    int                     pattern [64];     // 1 white, 2 black
    int                     latches = 0;
    int unsigned            seed;

    led_panel_top UUT (
        .clk         (clk),
        .pll_locked  (pll_locked),
        .fb_wr       (fb_wr),
        .fb_wr_lower (fb_wr_lower),
        .fb_wr_addr  (fb_wr_addr),
        .fb_wr_col   (fb_wr_col),
        .fb_wr_data  (fb_wr_data),
        .rgb0        (rgb0),
        .rgb1        (rgb1),
        .row_addr    (row_addr),
        .blank       (blank),
        .latch       (latch),
        .sclk        (sclk)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // channel scaled up to 8 bits and lit when above the mirrored subframe
    function automatic led_panel_pkg::rgb3_t expect_bits(
        input led_panel_pkg::rgb565_t px,
        input int                     sf
    );
        int                   thr;
        led_panel_pkg::rgb3_t bits;
        thr = 0;
        for (int i = 0; i < 8; i++) begin
            if (sf[i]) begin
                thr += 1 << (7 - i);
            end
        end
        bits.red   = (int'(px.red) * 8 > thr);
        bits.green = (int'(px.green) * 4 > thr);
        bits.blue  = (int'(px.blue) * 8 > thr);
        return bits;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_rgb3(input string name, input led_panel_pkg::rgb3_t got,
                                input led_panel_pkg::rgb3_t exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH %s: got %0h, expected %0h", name, got, exp));
        end
    endtask

    task automatic compare_addr(input string name, input led_panel_pkg::row_addr_t got,
                                input led_panel_pkg::row_addr_t exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH %s: got %0h, expected %0h", name, got, exp));
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH %s: got %0h, expected %0h", name, got, exp));
        end
    endtask

    // one write per falling edge with the model updated alongside
    task automatic write_pixel(input logic lower, input int addr, input int col,
                               input led_panel_pkg::rgb565_t data);
        fb_wr       = 1'b1;
        fb_wr_lower = lower;
        fb_wr_addr  = led_panel_pkg::row_addr_t'(addr);
        fb_wr_col   = led_panel_pkg::col_t'(col);
        fb_wr_data  = data;
        if (lower) begin
            ref_lower[addr * 64 + col] = data;
        end else begin
            ref_upper[addr * 64 + col] = data;
        end
        @(negedge clk);
    endtask

    task automatic check_idle_outputs();
        compare_bit("blank", blank, 1'b1);
        compare_bit("latch", latch, 1'b0);
        compare_bit("sclk", sclk, 1'b0);
        compare_rgb3("rgb0", rgb0, '0);
        compare_rgb3("rgb1", rgb1, '0);
        compare_addr("row_addr", row_addr, '0);
    endtask

    task automatic check_row(input int addr, input int sf);
        int idx;
        for (int col = 0; col < 64; col++) begin
            idx = addr * 64 + col;
            if (seen_sf[idx] != sf) begin
                report_failure($sformatf("row %0d column %0d was not shifted out in subframe %0d",
                                         addr, col, sf));
            end
            compare_rgb3($sformatf("rgb0 row %0d col %0d", addr, col), seen0[idx],
                         expect_bits(ref_upper[idx], sf));
            compare_rgb3($sformatf("rgb1 row %0d col %0d", addr, col), seen1[idx],
                         expect_bits(ref_lower[idx], sf));
        end
    endtask

    task automatic wait_latches(input int n);
        while (latches < n) begin
            @(negedge clk);
        end
    endtask

    // follows the scan by counting shift clocks and latch pulses
    task automatic monitor_panel();
        int                       shifts;
        int                       idx;
        logic                     addr_due;
        led_panel_pkg::row_addr_t exp_addr;
        shifts   = 0;
        addr_due = 1'b0;
        exp_addr = '0;
        forever begin
            @(negedge clk);
            if (addr_due) begin
                compare_addr("row_addr", row_addr, exp_addr);
                compare_bit("blank", blank, 1'b0);
                addr_due = 1'b0;
            end
            if (sclk) begin
                if (shifts >= 64) begin
                    report_failure("more than 64 shift clocks before a latch");
                end
                idx          = (latches % 32) * 64 + shifts;
                seen0[idx]   = rgb0;
                seen1[idx]   = rgb1;
                seen_sf[idx] = (latches / 32) % 256;
                shifts++;
            end
            if (latch) begin
                if (shifts != 64) begin
                    report_failure($sformatf("MISMATCH sclk pulses per row: got %0h, expected %0h",
                                             shifts, 64));
                end
                exp_addr = led_panel_pkg::row_addr_t'(latches % 32);
                addr_due = 1'b1;
                latches++;
                shifts = 0;
            end
        end
    endtask

    task automatic test_reset();
        repeat (3) begin
            @(negedge clk);
            check_idle_outputs();
        end
    endtask

    // clear upper then lower for each column in scan order from reset release
    task automatic test_row_sequence();
        for (int k = 0; k < 8; k++) begin
            pattern[$urandom % 64] = (k % 2 == 0) ? 1 : 2;
        end
        pll_locked = 1'b1;
        for (int r = 0; r < 32; r++) begin
            for (int c = 0; c < 64; c++) begin
                write_pixel(1'b0, r, c, '0);
                if (r == 0 && c == 0) begin
                    check_idle_outputs();
                end
                if (r == PATTERN_ROW && pattern[c] != 0) begin
                    write_pixel(1'b0, r, c, (pattern[c] == 1) ? 16'hffff : 16'h0000);
                end
                write_pixel(1'b1, r, c, '0);
            end
        end
        fb_wr = 1'b0;
        wait_latches(32);
    endtask

    task automatic test_full_zero();
        check_row(PATTERN_ROW, 0);
    endtask

    task automatic test_pwm_threshold();
        led_panel_pkg::rgb565_t px;
        px.red   = 5'd16;
        px.green = 6'd8;
        px.blue  = 5'd31;
        write_pixel(1'b0, 8, 10, px);
        fb_wr = 1'b0;
        wait_latches(32 + 9);
        check_row(8, 1);  // threshold 128
        wait_latches(64 + 9);
        check_row(8, 2);  // threshold 64
    endtask

    task automatic test_halves();
        write_pixel(1'b0, 24, 33, 16'hf800);  // red only
        write_pixel(1'b1, 24, 33, 16'hffff);
        fb_wr = 1'b0;
        wait_latches(64 + 26);
        check_row(24, 2);
        check_row(25, 2);
    endtask

    initial begin
        seed        = $urandom(32'hc4ee);
        pll_locked  = 1'b0;
        fb_wr       = 1'b0;
        fb_wr_lower = 1'b0;
        fb_wr_addr  = '0;
        fb_wr_col   = '0;
        fb_wr_data  = '0;
        for (int i = 0; i < PIX; i++) begin
            seen_sf[i] = -1;
        end
        test_reset();
        test_row_sequence();
        test_full_zero();
        test_pwm_threshold();
        test_halves();
        $display("Test passed");
        $finish;
    end

    initial begin
        monitor_panel();
    end

    // six full subframes
    initial begin
        #(6 * led_panel_pkg::ROW_CYCLES * led_panel_pkg::ROW_COUNT * CLK_PERIOD);
        report_failure("timeout, the scan did not reach the end of the tests");
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
led_panel_pkg.sv
pixel_if.sv
scan_counter.sv
frame_buffer.sv
pwm_modulator.sv
panel_driver.sv
led_panel_top.sv
led_panel_sva.sv
tb_led_panel.sv

// ==== Bender.yml ====
package:
  name: led_panel

sources:
  - led_panel_pkg.sv
  - pixel_if.sv
  - scan_counter.sv
  - frame_buffer.sv
  - pwm_modulator.sv
  - panel_driver.sv
  - led_panel_top.sv
  - target: test
    files:
      - led_panel_sva.sv
      - tb_led_panel.sv
